// File: hdl/hmc_consts.svh
`ifndef HMC_CONSTS_SVH
`define HMC_CONSTS_SVH

// ************************************************************************
// timing
// ************************************************************************

// power-up wait before the first frame, in clk cycles
`define STARTUP_CYCLES 256

// serial frame length in bits
`define FRAME_BITS 32

// ************************************************************************
// word counts and indices
// ************************************************************************

`define INIT_WORDS 13
`define TUNE_WORDS 3
`define WORD_IDX_W 4

// step counter and its limit
`define STEP_CNT_W 21

// tuning registers
`define REG_INT 6'h03
`define REG_FRAC 6'h04
`define REG_VCO 6'h05

`endif

// File: hdl/pll_reg_pkg.sv
`include "hmc_consts.svh"

package pll_reg_pkg;

	// one register write as it goes out on the serial port
	typedef struct packed
	{
		logic [1:0] spare;
		logic [5:0] addr;
		logic [23:0] data;
	} pll_word_t;

	// live frequency setting
	typedef struct packed
	{
		logic [7:0] int_part;
		logic [23:0] frac_part;
	} freq_word_t;

	// position in the init and tuning word sequence
	typedef logic [`WORD_IDX_W-1:0] word_idx_t;

endpackage

// File: hdl/spi_pkg.sv
package spi_pkg;

	// three-wire write port pins
	typedef struct packed
	{
		logic sck;
		logic sen;
		logic sdi;
	} spi_pins_t;

endpackage

// File: hdl/pll_timers.sv
`include "hmc_consts.svh"

module pll_timers
(
	input logic clk,
	input logic rst_n,
	input logic step_pulse,
	input logic step_enable,
	input logic [`STEP_CNT_W-1:0] step_limit,
	output logic startup_done,
	output logic step_wrap,
	output logic step_hit
);

	localparam int PWR_W = $clog2(`STARTUP_CYCLES);

	logic [PWR_W-1:0] pwr_cnt;
	logic [`STEP_CNT_W-1:0] step_cnt;

	// power-up delay, holds once done
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pwr_cnt <= '0;
			startup_done <= 1'b0;
		end
		else if (!startup_done)
		begin
			if (pwr_cnt == PWR_W'(`STARTUP_CYCLES - 1))
				startup_done <= 1'b1;
			else
				pwr_cnt <= pwr_cnt + 1'b1;
		end
	end

	// step counter, only counts in idle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step_cnt <= '0;
			step_wrap <= 1'b0;
			step_hit <= 1'b0;
		end
		else
		begin
			step_wrap <= 1'b0;
			step_hit <= (step_cnt == step_limit);
			if (step_enable && step_pulse)
			begin
				if (step_cnt == step_limit)
				begin
					step_cnt <= '0;
					step_wrap <= 1'b1;
				end
				else
					step_cnt <= step_cnt + 1'b1;
			end
		end
	end

endmodule

// File: hdl/config_rom.sv
`include "hmc_consts.svh"

module config_rom
	import pll_reg_pkg::*;
(
	input word_idx_t word_idx,
	input freq_word_t freq_word,
	output pll_word_t word
);

	localparam word_idx_t IDX_INT = word_idx_t'(`INIT_WORDS);
	localparam word_idx_t IDX_FRAC = word_idx_t'(`INIT_WORDS + 1);
	localparam word_idx_t IDX_VCO = word_idx_t'(`INIT_WORDS + 2);

	// ********************************************************************
	// fixed init sequence, reference divider then VCO subsystem
	// ********************************************************************
	localparam pll_word_t INIT_TABLE [`INIT_WORDS] = '{
		32'h02000001,
		32'h06200B4A,
		32'h070008CD,
		32'h08C1BEFF,
		32'h09403264,
		32'h0A002046,
		32'h0F0000C1,
		32'h05000F88,
		32'h05006E10,
		32'h05002A18,
		32'h05001628,
		32'h050060A0,
		32'h05000000
	};

	always_comb
	begin
		word = '0;
		unique case (word_idx)
			IDX_INT:
			begin
				word.addr = `REG_INT;
				word.data = {16'h0000, freq_word.int_part};
			end
			IDX_FRAC:
			begin
				word.addr = `REG_FRAC;
				word.data = freq_word.frac_part;
			end
			// zero write kicks off VCO autocal
			IDX_VCO:
				word.addr = `REG_VCO;
			default:
				word = INIT_TABLE[word_idx];
		endcase
	end

endmodule

// File: hdl/spi_frame_shifter.sv
`include "hmc_consts.svh"

module spi_frame_shifter
	import pll_reg_pkg::*;
	import spi_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic frame_start,
	input pll_word_t word,
	output logic frame_done,
	output spi_pins_t spi
);

	localparam int CNT_W = $clog2(`FRAME_BITS);

	logic [`FRAME_BITS-1:0] frame;
	logic [`FRAME_BITS-1:0] shift_q;
	logic [CNT_W-1:0] bit_cnt;
	logic tail;
	logic load;
	logic last_bit;
	logic shift;

	// write bit, address, data, trailing zero
	assign frame = {1'b0, word.addr, word.data, 1'b0};

	assign load = frame_start && !spi.sen;
	assign last_bit = (bit_cnt == CNT_W'(`FRAME_BITS - 1));
	// next bit goes out at the end of each sck high phase
	assign shift = spi.sen && spi.sck && !last_bit;

	always_ff @(posedge clk)
	begin
		if (load)
			shift_q <= frame << 1;
		else if (shift)
			shift_q <= shift_q << 1;
	end

	// ********************************************************************
	// pin sequencing: sck low one cycle, high one cycle per bit
	// ********************************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			spi <= '0;
			bit_cnt <= '0;
			tail <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			tail <= 1'b0;
			frame_done <= tail;
			if (load)
			begin
				spi.sen <= 1'b1;
				spi.sck <= 1'b0;
				spi.sdi <= frame[`FRAME_BITS-1];
				bit_cnt <= '0;
			end
			else if (spi.sen)
			begin
				if (!spi.sck)
					spi.sck <= 1'b1;
				else if (last_bit)
				begin
					spi <= '0;
					tail <= 1'b1;
				end
				else
				begin
					spi.sck <= 1'b0;
					spi.sdi <= shift_q[`FRAME_BITS-1];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/pll_sequencer.sv
`include "hmc_consts.svh"

module pll_sequencer
	import pll_reg_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic startup_done,
	input logic step_wrap,
	input logic jump_pulse,
	input logic jump_enable,
	input logic frame_done,
	output logic step_enable,
	output word_idx_t word_idx,
	output logic frame_start
);

	localparam word_idx_t FIRST_TUNE = word_idx_t'(`INIT_WORDS);
	localparam word_idx_t LAST_IDX = word_idx_t'(`INIT_WORDS + `TUNE_WORDS - 1);

	typedef enum logic [1:0]
	{
		ST_WAIT_PWR,
		ST_SEND,
		ST_WAIT_FRAME,
		ST_IDLE
	} state_t;

	state_t state;
	logic retune;

	// step wrap or enabled jump, only acted on in idle
	assign retune = step_wrap || (jump_pulse && jump_enable);

	assign frame_start = (state == ST_SEND);
	assign step_enable = (state == ST_IDLE);

	// ********************************************************************
	// init words, then tuning words, then idle
	// ********************************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_WAIT_PWR;
			word_idx <= '0;
		end
		else
		begin
			case (state)
				ST_WAIT_PWR:
				begin
					if (startup_done)
						state <= ST_SEND;
				end
				ST_SEND:
					state <= ST_WAIT_FRAME;
				ST_WAIT_FRAME:
				begin
					if (frame_done)
					begin
						if (word_idx == LAST_IDX)
							state <= ST_IDLE;
						else
						begin
							word_idx <= word_idx + 1'b1;
							state <= ST_SEND;
						end
					end
				end
				ST_IDLE:
				begin
					if (retune)
					begin
						word_idx <= FIRST_TUNE;
						state <= ST_SEND;
					end
				end
				default:
					state <= ST_WAIT_PWR;
			endcase
		end
	end

endmodule

// File: hdl/hmc830_config.sv
`include "hmc_consts.svh"

module hmc830_config
	import pll_reg_pkg::*;
	import spi_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input freq_word_t freq_word,
	input logic step_pulse,
	input logic jump_pulse,
	input logic jump_enable,
	input logic [`STEP_CNT_W-1:0] step_limit,
	output spi_pins_t spi,
	output logic step_hit
);

	logic startup_done;
	logic step_wrap;
	logic step_enable;
	word_idx_t word_idx;
	logic frame_start;
	logic frame_done;
	pll_word_t word;

	pll_timers i_timers
	(
		.clk(clk),
		.rst_n(rst_n),
		.step_pulse(step_pulse),
		.step_enable(step_enable),
		.step_limit(step_limit),
		.startup_done(startup_done),
		.step_wrap(step_wrap),
		.step_hit(step_hit)
	);

	pll_sequencer i_sequencer
	(
		.clk(clk),
		.rst_n(rst_n),
		.startup_done(startup_done),
		.step_wrap(step_wrap),
		.jump_pulse(jump_pulse),
		.jump_enable(jump_enable),
		.frame_done(frame_done),
		.step_enable(step_enable),
		.word_idx(word_idx),
		.frame_start(frame_start)
	);

	config_rom i_rom
	(
		.word_idx(word_idx),
		.freq_word(freq_word),
		.word(word)
	);

	spi_frame_shifter i_shifter
	(
		.clk(clk),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.word(word),
		.frame_done(frame_done),
		.spi(spi)
	);

endmodule

// File: bench/spi_frame_monitor.sv
`include "hmc_consts.svh"

module spi_frame_monitor
	import spi_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input spi_pins_t spi,
	output logic frame_valid,
	output logic [`FRAME_BITS-1:0] frame,
	output logic [7:0] sck_rises
);

	logic sck_q;
	logic sen_q;
	logic [`FRAME_BITS-1:0] shift_q;
	logic [7:0] rise_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sck_q <= 1'b0;
			sen_q <= 1'b0;
			rise_cnt <= '0;
			frame_valid <= 1'b0;
		end
		else
		begin
			sck_q <= spi.sck;
			sen_q <= spi.sen;
			frame_valid <= 1'b0;
			// sdi taken on each sck rise inside sen
			if (spi.sen && spi.sck && !sck_q)
			begin
				shift_q <= {shift_q[`FRAME_BITS-2:0], spi.sdi};
				rise_cnt <= rise_cnt + 1'b1;
			end
			// sen falling closes the frame
			if (sen_q && !spi.sen)
			begin
				frame_valid <= 1'b1;
				frame <= shift_q;
				sck_rises <= rise_cnt;
				shift_q <= '0;
				rise_cnt <= '0;
			end
		end
	end

endmodule

// File: bench/hmc830_config_tb.sv
`include "hmc_consts.svh"

module hmc830_config_tb
	import pll_reg_pkg::*;
	import spi_pkg::*;
();

	localparam int FRAME_CYCLES = 2 * `FRAME_BITS + 3;
	localparam int NUM_ROWS = 11;
	localparam int PULSE_GAP = 3;
	localparam int QUIET_CYCLES = 80;

	typedef enum logic [1:0] {OP_WAIT_IDLE, OP_STEPS, OP_JUMP} op_t;

	typedef struct packed
	{
		op_t op;
		freq_word_t freq;
		logic [`STEP_CNT_W-1:0] limit;
		logic [7:0] pulses;
		logic jump_en;
		logic exp_hit;
	} row_t;

	// ************************************************************************
	// stimulus table, freq filled from the lcg
	// ************************************************************************
	row_t rows [NUM_ROWS] = '{
		'{OP_WAIT_IDLE, '0, 21'd3, 8'd0, 1'b0, 1'b0},
		'{OP_STEPS, '0, 21'd3, 8'd3, 1'b0, 1'b1},
		'{OP_STEPS, '0, 21'd3, 8'd1, 1'b0, 1'b0},
		'{OP_STEPS, '0, 21'd5, 8'd5, 1'b1, 1'b1},
		'{OP_JUMP, '0, 21'd5, 8'd6, 1'b1, 1'b1},
		'{OP_JUMP, '0, 21'd5, 8'd0, 1'b0, 1'b1},
		'{OP_STEPS, '0, 21'd5, 8'd1, 1'b0, 1'b0},
		'{OP_STEPS, '0, 21'd2, 8'd4, 1'b0, 1'b0},
		'{OP_STEPS, '0, 21'd2, 8'd1, 1'b1, 1'b1},
		'{OP_JUMP, '0, 21'd2, 8'd4, 1'b1, 1'b1},
		'{OP_WAIT_IDLE, '0, 21'd2, 8'd0, 1'b0, 1'b1}
	};

	// device init words, reference divider then VCO subsystem
	localparam logic [31:0] INIT_TABLE [`INIT_WORDS] = '{
		32'h02000001, 32'h06200B4A, 32'h070008CD, 32'h08C1BEFF,
		32'h09403264, 32'h0A002046, 32'h0F0000C1, 32'h05000F88,
		32'h05006E10, 32'h05002A18, 32'h05001628, 32'h050060A0,
		32'h05000000
	};

	logic clk = 1'b0;
	logic rst_n;
	freq_word_t freq_word;
	logic step_pulse;
	logic jump_pulse;
	logic jump_enable;
	logic [`STEP_CNT_W-1:0] step_limit;
	spi_pins_t spi;
	logic step_hit;
	logic frame_valid;
	logic [`FRAME_BITS-1:0] frame;
	logic [7:0] sck_rises;
	logic [31:0] expected_q [$];
	logic [31:0] lcg_state = 32'd8;
	int unsigned step_count = 0;
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit;

	always #5 clk = ~clk;

	hmc830_config i_dut (.*);

	spi_frame_monitor i_monitor (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// write bit, address, data, trailing zero
	function automatic logic [31:0] frame_of(input pll_word_t w);
		return {1'b0, w.addr, w.data, 1'b0};
	endfunction

	task automatic push_tuning(input freq_word_t f);
		pll_word_t w;
		w = '0;
		w.addr = `REG_INT;
		w.data = {16'h0000, f.int_part};
		expected_q.push_back(frame_of(w));
		w.addr = `REG_FRAC;
		w.data = f.frac_part;
		expected_q.push_back(frame_of(w));
		w.addr = `REG_VCO;
		w.data = '0;
		expected_q.push_back(frame_of(w));
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_idle();
		while (expected_q.size() != 0)
			@(negedge clk);
		repeat (3)
			@(posedge clk);
		check_value(spi.sen, 0, "sen after the last frame");
	endtask

	task automatic quiet(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			check_value(spi.sen, 0, "sen while no frame is due");
		end
	endtask

	task automatic pulse(input logic step, input logic jump);
		@(posedge clk);
		step_pulse <= step;
		jump_pulse <= jump;
		@(posedge clk);
		step_pulse <= 1'b0;
		jump_pulse <= 1'b0;
		repeat (PULSE_GAP)
			@(posedge clk);
	endtask

	task automatic run_row(input row_t row);
		case (row.op)
			OP_STEPS:
			begin
				for (int p = 0; p < row.pulses; p++)
				begin
					// a pulse at the limit wraps the count and retunes
					if (step_count == row.limit)
					begin
						push_tuning(row.freq);
						pulse(1'b1, 1'b0);
						step_count = 0;
						wait_idle();
					end
					else
					begin
						pulse(1'b1, 1'b0);
						step_count++;
					end
				end
			end
			OP_JUMP:
			begin
				if (row.jump_en)
					push_tuning(row.freq);
				pulse(1'b0, 1'b1);
				if (row.jump_en)
				begin
					// these land while tuning frames are on the wire
					for (int p = 0; p < row.pulses; p++)
						pulse(1'b1, 1'b1);
					wait_idle();
				end
			end
			default:
				wait_idle();
		endcase
	endtask

	// ************************************************************************
	// frame checker and run limit
	// ************************************************************************
	always @(posedge clk)
	begin
		if (frame_valid)
		begin
			if (expected_q.size() == 0)
			begin
				$display("Error at %0t: frame %h was sent while none was expected", $time, frame);
				$display("Some tests failed");
				$fatal(1);
			end
			else
			begin
				check_value(sck_rises, `FRAME_BITS, "sck rises in a frame");
				check_value(frame, expected_q.pop_front(), "frame contents");
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("Error: the run did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	initial
	begin
		cycle_limit = 5 + `STARTUP_CYCLES + 16 * FRAME_CYCLES + 200;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			lcg_state = lcg_next(lcg_state);
			rows[r].freq = lcg_state;
			cycle_limit += 3 * FRAME_CYCLES + QUIET_CYCLES + 10
				+ rows[r].pulses * (PULSE_GAP + 8);
		end
		rst_n = 1'b0;
		freq_word = rows[0].freq;
		step_pulse = 1'b0;
		jump_pulse = 1'b0;
		jump_enable = rows[0].jump_en;
		step_limit = rows[0].limit;
		for (int i = 0; i < `INIT_WORDS; i++)
			expected_q.push_back(frame_of(INIT_TABLE[i]));
		push_tuning(rows[0].freq);
		repeat (5)
			@(posedge clk);
		rst_n <= 1'b1;
		// startup_done, frame_start and the shifter load take one edge each
		for (int i = 0; i < `STARTUP_CYCLES + 2; i++)
		begin
			@(posedge clk);
			check_value(spi.sen | spi.sck, 0, "sen or sck during the power-up wait");
		end
		@(posedge clk);
		check_value(spi.sen, 1, "sen right after the power-up wait");
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(posedge clk);
			freq_word <= rows[r].freq;
			step_limit <= rows[r].limit;
			jump_enable <= rows[r].jump_en;
			run_row(rows[r]);
			quiet(QUIET_CYCLES);
			check_value(step_hit, rows[r].exp_hit, $sformatf("step_hit after row %0d", r));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+hdl
hdl/pll_reg_pkg.sv
hdl/spi_pkg.sv
hdl/pll_timers.sv
hdl/config_rom.sv
hdl/spi_frame_shifter.sv
hdl/pll_sequencer.sv
hdl/hmc830_config.sv
bench/spi_frame_monitor.sv
bench/hmc830_config_tb.sv

// File: Bender.yml
package:
  name: hmc830_config

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pll_reg_pkg.sv
      - hdl/spi_pkg.sv
      - hdl/pll_timers.sv
      - hdl/config_rom.sv
      - hdl/spi_frame_shifter.sv
      - hdl/pll_sequencer.sv
      - hdl/hmc830_config.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/spi_frame_monitor.sv
      - bench/hmc830_config_tb.sv
